//--- common/htu_pkg.sv
package htu_pkg;

  localparam int ADDR_W   = 32;
  localparam int NUM_SETS = 8;
  localparam int MAX_WAYS = 8;

  // ------------------------------
  // address fields
  // ------------------------------
  typedef logic [ADDR_W-1:10]            tag_t;
  typedef logic [$clog2(NUM_SETS)-1:0]   index_t;
  typedef logic [$clog2(MAX_WAYS)-1:0]   way_t;
  typedef logic [ADDR_W-1:5]             line_addr_t;
  typedef logic [5:0]                    set_way_t;
  typedef logic [1:0]                    ch_id_t;

  // codes 2 and 3 not used by this bank
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1
  } htu_op_e;

  typedef enum logic [1:0] {
    LS_EMPTY = 2'd0,
    LS_CLEAN = 2'd1,
    LS_DIRTY = 2'd3
  } line_state_e;

  // ------------------------------
  // bundles
  // ------------------------------
  typedef struct packed {
    ch_id_t            ch_id;
    htu_op_e           op;
    logic [ADDR_W-1:4] addr;
  } htu_req_t;

  typedef struct packed {
    logic        hit;
    way_t        way;
    line_state_e off0_state;
    line_state_e off1_state;
    logic        victim_dirty;
  } htu_lookup_t;

  // opcode[0] is write, opcode[1] is need evict
  typedef struct packed {
    logic        need_linefill;
    ch_id_t      ch_id;
    logic [1:0]  opcode;
    logic [6:0]  set_way_offset;
    line_state_e off0_state;
    line_state_e off1_state;
  } htu_isu_t;

endpackage

//--- set_array/htu_set_entry.sv
`timescale 1ns/1ns

module htu_set_entry
  import htu_pkg::*;
#(
  parameter int NUM_WAYS = 8
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sel_i,
  input  logic        update_en_i,
  input  logic        update_write_i,
  input  tag_t        tag_i,
  input  logic        offset_i,
  output logic        hit_o,
  output way_t        way_o,
  output line_state_e off0_state_o,
  output line_state_e off1_state_o,
  output logic        victim_dirty_o
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  tag_t                tag_q  [NUM_WAYS];
  line_state_e         off0_q [NUM_WAYS];
  line_state_e         off1_q [NUM_WAYS];
  logic [WAY_W-1:0]    victim_q;

  logic [NUM_WAYS-1:0] way_hit;
  logic                hit_any;
  logic [WAY_W-1:0]    hit_way;
  logic [WAY_W-1:0]    sel_way;
  line_state_e         cur_off0;
  line_state_e         cur_off1;
  line_state_e         cur_acc;
  line_state_e         cur_other;
  line_state_e         nxt_acc;
  line_state_e         nxt_other;
  line_state_e         nxt_off0;
  line_state_e         nxt_off1;
  logic                upd;

  // ------------------------------
  // lookup
  // ------------------------------
  // a way with both halves empty holds no line
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = (tag_q[w] == tag_i)
                 && ((off0_q[w] != LS_EMPTY) || (off1_q[w] != LS_EMPTY));
    end
  end

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  assign hit_any  = |way_hit;
  assign sel_way  = hit_any ? hit_way : victim_q;
  assign cur_off0 = off0_q[sel_way];
  assign cur_off1 = off1_q[sel_way];

  assign hit_o          = hit_any;
  assign way_o          = way_t'(sel_way);
  assign off0_state_o   = cur_off0;
  assign off1_state_o   = cur_off1;
  assign victim_dirty_o = (off0_q[victim_q] == LS_DIRTY) || (off1_q[victim_q] == LS_DIRTY);

  // ------------------------------
  // next half states
  // ------------------------------
  assign cur_acc   = offset_i ? cur_off1 : cur_off0;
  assign cur_other = offset_i ? cur_off0 : cur_off1;

  always_comb begin
    if (update_write_i) begin
      nxt_acc = LS_DIRTY;
    end else if (!hit_any || (cur_acc == LS_EMPTY)) begin
      nxt_acc = LS_CLEAN;
    end else begin
      nxt_acc = cur_acc;
    end
  end

  // a fresh allocation starts with the untouched half empty
  assign nxt_other = hit_any ? cur_other : LS_EMPTY;
  assign nxt_off0  = offset_i ? nxt_other : nxt_acc;
  assign nxt_off1  = offset_i ? nxt_acc : nxt_other;

  assign upd = sel_i & update_en_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        off0_q[w] <= LS_EMPTY;
        off1_q[w] <= LS_EMPTY;
      end
      victim_q <= '0;
    end else if (upd) begin
      off0_q[sel_way] <= nxt_off0;
      off1_q[sel_way] <= nxt_off1;
      // round robin, wraps since NUM_WAYS is a power of two
      if (!hit_any) begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd && !hit_any) begin
      tag_q[victim_q] <= tag_i;
    end
  end

endmodule

//--- set_array/htu_set_array.sv
`timescale 1ns/1ns

module htu_set_array
  import htu_pkg::*;
#(
  parameter int NUM_WAYS = 8
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  index_t      index_i,
  input  tag_t        tag_i,
  input  logic        offset_i,
  input  logic        update_en_i,
  input  logic        update_write_i,
  output htu_lookup_t lookup_o
);

  logic [NUM_SETS-1:0] set_sel;
  logic                set_hit    [NUM_SETS];
  way_t                set_way    [NUM_SETS];
  line_state_e         set_off0   [NUM_SETS];
  line_state_e         set_off1   [NUM_SETS];
  logic                set_vdirty [NUM_SETS];

  // one-hot set select
  always_comb begin
    for (int s = 0; s < NUM_SETS; s++) begin
      set_sel[s] = (index_i == index_t'(s));
    end
  end

  // ------------------------------
  // sets
  // ------------------------------
  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    htu_set_entry #(
      .NUM_WAYS (NUM_WAYS)
    ) u_set_entry (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .sel_i          (set_sel[s]),
      .update_en_i    (update_en_i),
      .update_write_i (update_write_i),
      .tag_i          (tag_i),
      .offset_i       (offset_i),
      .hit_o          (set_hit[s]),
      .way_o          (set_way[s]),
      .off0_state_o   (set_off0[s]),
      .off1_state_o   (set_off1[s]),
      .victim_dirty_o (set_vdirty[s])
    );
  end

  // ------------------------------
  // result of the addressed set
  // ------------------------------
  always_comb begin
    lookup_o.hit        = set_hit[index_i];
    lookup_o.way        = set_way[index_i];
    lookup_o.off0_state = set_off0[index_i];
    lookup_o.off1_state = set_off1[index_i];
    // only a miss throws the victim out
    lookup_o.victim_dirty = set_vdirty[index_i] & ~set_hit[index_i];
  end

endmodule

//--- logic/htu_dispatch.sv
`timescale 1ns/1ns

module htu_dispatch
  import htu_pkg::*;
(
  input  logic        req_valid_i,
  input  htu_req_t    req_i,
  input  htu_lookup_t lookup_i,
  input  logic        isu_allow_in_i,
  input  logic        biu_arready_i,
  output logic        allow_in_o,
  output logic        isu_valid_o,
  output htu_isu_t    isu_o,
  output logic        biu_arvalid_o,
  output line_addr_t  biu_araddr_o,
  output set_way_t    biu_set_way_o,
  output logic        update_en_o,
  output logic        update_write_o
);

  logic        op_is_read;
  logic        op_is_write;
  index_t      index;
  logic        offset;
  line_state_e acc_state;
  logic        need_refill;
  logic        need_evict;
  logic        refill_ok;

  // ------------------------------
  // decode
  // ------------------------------
  assign op_is_read  = (req_i.op == OP_READ);
  assign op_is_write = (req_i.op == OP_WRITE);
  assign index       = req_i.addr[7:5];
  assign offset      = req_i.addr[4];

  assign acc_state = offset ? lookup_i.off1_state : lookup_i.off0_state;

  // read miss, or read hit to a half not yet filled
  assign need_refill = op_is_read & (~lookup_i.hit | (acc_state == LS_EMPTY));

  // victim_dirty already qualified with miss in the array
  assign need_evict = lookup_i.victim_dirty;

  // ------------------------------
  // handshakes
  // ------------------------------
  assign refill_ok     = ~need_refill | biu_arready_i;
  assign allow_in_o    = isu_allow_in_i & refill_ok;
  assign isu_valid_o   = req_valid_i & refill_ok;
  assign biu_arvalid_o = req_valid_i & need_refill & isu_allow_in_i;

  // kickoff
  assign update_en_o    = req_valid_i & allow_in_o;
  assign update_write_o = op_is_write;

  // ------------------------------
  // issue and refill payload
  // ------------------------------
  always_comb begin
    isu_o.need_linefill  = need_refill;
    isu_o.ch_id          = req_i.ch_id;
    isu_o.opcode         = {need_evict, op_is_write};
    isu_o.set_way_offset = {index, lookup_i.way, offset};
    isu_o.off0_state     = lookup_i.off0_state;
    isu_o.off1_state     = lookup_i.off1_state;
  end

  assign biu_araddr_o  = req_i.addr[ADDR_W-1:5];
  assign biu_set_way_o = {index, lookup_i.way};

endmodule

//--- logic/bank_htu_top.sv
`timescale 1ns/1ns

module bank_htu_top
  import htu_pkg::*;
#(
  parameter int NUM_WAYS = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // crossbar request
  input  logic       req_valid_i,
  input  htu_req_t   req_i,
  output logic       allow_in_o,
  // issue unit
  output logic       isu_valid_o,
  output htu_isu_t   isu_o,
  input  logic       isu_allow_in_i,
  // linefill read
  output logic       biu_arvalid_o,
  output line_addr_t biu_araddr_o,
  output set_way_t   biu_set_way_o,
  input  logic       biu_arready_i
);

  htu_lookup_t lookup;
  logic        update_en;
  logic        update_write;

  htu_set_array #(
    .NUM_WAYS (NUM_WAYS)
  ) u_set_array (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .index_i        (req_i.addr[7:5]),
    .tag_i          (req_i.addr[ADDR_W-1:10]),
    .offset_i       (req_i.addr[4]),
    .update_en_i    (update_en),
    .update_write_i (update_write),
    .lookup_o       (lookup)
  );

  htu_dispatch u_dispatch (
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .lookup_i       (lookup),
    .isu_allow_in_i (isu_allow_in_i),
    .biu_arready_i  (biu_arready_i),
    .allow_in_o     (allow_in_o),
    .isu_valid_o    (isu_valid_o),
    .isu_o          (isu_o),
    .biu_arvalid_o  (biu_arvalid_o),
    .biu_araddr_o   (biu_araddr_o),
    .biu_set_way_o  (biu_set_way_o),
    .update_en_o    (update_en),
    .update_write_o (update_write)
  );

endmodule

//--- testbench/bank_htu_properties.sv
`timescale 1ns/1ns

module bank_htu_properties
  import htu_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       req_valid_i,
  input htu_req_t   req_i,
  input logic       isu_allow_in_i,
  input logic       allow_in_o,
  input logic       isu_valid_o,
  input htu_isu_t   isu_o,
  input logic       biu_arvalid_o,
  input line_addr_t biu_araddr_o,
  input set_way_t   biu_set_way_o
);

  // ------------------------------
  // handshake rules
  // ------------------------------
  a_arvalid_needs_isu: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_arvalid_o |-> isu_allow_in_i)
    else $error("linefill request raised while the issue unit is stalled");

  a_allow_needs_isu: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    allow_in_o |-> isu_allow_in_i)
    else $error("request accepted while the issue unit is stalled");

  // only read and write reach this bank
  a_op_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (req_i.op == OP_READ || req_i.op == OP_WRITE))
    else $error("illegal opcode on a valid request");

  a_outputs_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({allow_in_o, isu_valid_o, isu_o, biu_arvalid_o, biu_araddr_o, biu_set_way_o}))
    else $error("unknown value on an output");

endmodule

bind bank_htu_top bank_htu_properties u_properties (.*);

//--- testbench/tb_bank_htu.sv
`timescale 1ns/1ns

module tb_bank_htu;
  import htu_pkg::*;

  localparam int NUM_WAYS   = 8;
  localparam int CLK_PERIOD = 20;
  // reset, idle gaps, directed requests and both eviction sweeps
  localparam int TEST_CYCLES = 24 + 2 * (NUM_WAYS + 2);

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  htu_req_t   req;
  logic       allow_in;
  logic       isu_valid;
  htu_isu_t   isu;
  logic       isu_allow_in;
  logic       biu_arvalid;
  line_addr_t biu_araddr;
  set_way_t   biu_set_way;
  logic       biu_arready;

  // reference model of the set array
  tag_t       ref_tag [NUM_SETS][NUM_WAYS];
  logic [1:0] ref_s0  [NUM_SETS][NUM_WAYS];
  logic [1:0] ref_s1  [NUM_SETS][NUM_WAYS];
  int         ref_vp  [NUM_SETS];

  htu_isu_t   last_isu;

  bank_htu_top #(
    .NUM_WAYS (NUM_WAYS)
  ) dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .allow_in_o     (allow_in),
    .isu_valid_o    (isu_valid),
    .isu_o          (isu),
    .isu_allow_in_i (isu_allow_in),
    .biu_arvalid_o  (biu_arvalid),
    .biu_araddr_o   (biu_araddr),
    .biu_set_way_o  (biu_set_way),
    .biu_arready_i  (biu_arready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  // ------------------------------
  // request driver and model
  // ------------------------------
  task automatic send_request(input logic is_write, input tag_t tag, input index_t idx,
                              input logic off, input logic allow, input logic ready);
    logic       hit;
    int         way;
    logic [1:0] acc;
    logic       refill;
    logic       evict;
    logic       go;
    ch_id_t     ch;
    ch = ch_id_t'($urandom());
    @(posedge clk);
    req_valid    <= 1'b1;
    req.ch_id    <= ch;
    if (is_write) begin
      req.op <= OP_WRITE;
    end else begin
      req.op <= OP_READ;
    end
    req.addr     <= {tag, 2'b00, idx, off};
    isu_allow_in <= allow;
    biu_arready  <= ready;
    @(negedge clk);
    hit = 1'b0;
    way = ref_vp[idx];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ref_tag[idx][w] == tag && (ref_s0[idx][w] != LS_EMPTY || ref_s1[idx][w] != LS_EMPTY)) begin
        hit = 1'b1;
        way = w;
      end
    end
    acc    = off ? ref_s1[idx][way] : ref_s0[idx][way];
    refill = !is_write && (!hit || acc == LS_EMPTY);
    evict  = !hit && (ref_s0[idx][way] == LS_DIRTY || ref_s1[idx][way] == LS_DIRTY);
    go     = allow && (!refill || ready);
    check_value("allow_in", 32'(allow_in), 32'(go));
    check_value("isu_valid", 32'(isu_valid), 32'(!refill || ready));
    check_value("biu_arvalid", 32'(biu_arvalid), 32'(refill && allow));
    check_value("need_linefill", 32'(isu.need_linefill), 32'(refill));
    check_value("ch_id", 32'(isu.ch_id), 32'(ch));
    check_value("opcode", 32'(isu.opcode), 32'({evict, is_write}));
    check_value("set_way_offset", 32'(isu.set_way_offset), 32'({idx, 3'(way), off}));
    check_value("off0_state", 32'(isu.off0_state), 32'(ref_s0[idx][way]));
    check_value("off1_state", 32'(isu.off1_state), 32'(ref_s1[idx][way]));
    check_value("biu_araddr", 32'(biu_araddr), 32'({tag, 2'b00, idx}));
    check_value("biu_set_way", 32'(biu_set_way), 32'({idx, 3'(way)}));
    last_isu = isu;
    // state moves on the edge that ends this cycle
    if (go && !hit) begin
      ref_tag[idx][way] = tag;
      ref_s0[idx][way]  = LS_EMPTY;
      ref_s1[idx][way]  = LS_EMPTY;
      ref_vp[idx]       = (ref_vp[idx] + 1) % NUM_WAYS;
    end
    if (go) begin
      acc = off ? ref_s1[idx][way] : ref_s0[idx][way];
      if (is_write) begin
        acc = LS_DIRTY;
      end else if (acc == LS_EMPTY) begin
        acc = LS_CLEAN;
      end
      if (off) begin
        ref_s1[idx][way] = acc;
      end else begin
        ref_s0[idx][way] = acc;
      end
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    req_valid    <= 1'b0;
    isu_allow_in <= 1'b1;
    biu_arready  <= 1'b1;
    @(negedge clk);
    check_value("idle isu_valid", 32'(isu_valid), 32'd0);
    check_value("idle biu_arvalid", 32'(biu_arvalid), 32'd0);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_read_miss_then_hit(input tag_t t);
    send_request(1'b0, t, 3'd1, 1'b0, 1'b1, 1'b1);
    check_value("first read linefill", 32'(last_isu.need_linefill), 32'd1);
    check_value("first read way", 32'(last_isu.set_way_offset[3:1]), 32'd0);
    send_request(1'b0, t, 3'd1, 1'b0, 1'b1, 1'b1);
    check_value("second read linefill", 32'(last_isu.need_linefill), 32'd0);
    go_idle();
  endtask

  task automatic test_other_half(input tag_t t);
    send_request(1'b0, t, 3'd1, 1'b1, 1'b1, 1'b1);
    check_value("other half linefill", 32'(last_isu.need_linefill), 32'd1);
    send_request(1'b0, t, 3'd1, 1'b1, 1'b1, 1'b1);
    check_value("half 0 clean", 32'(last_isu.off0_state), 32'(LS_CLEAN));
    check_value("half 1 clean", 32'(last_isu.off1_state), 32'(LS_CLEAN));
    go_idle();
  endtask

  task automatic test_write_miss(input tag_t t);
    send_request(1'b1, t, 3'd2, 1'b0, 1'b1, 1'b1);
    check_value("write miss linefill", 32'(last_isu.need_linefill), 32'd0);
    send_request(1'b1, t, 3'd2, 1'b0, 1'b1, 1'b1);
    check_value("write hit half", 32'(last_isu.off0_state), 32'(LS_DIRTY));
    send_request(1'b0, t, 3'd2, 1'b0, 1'b1, 1'b1);
    check_value("half stays dirty", 32'(last_isu.off0_state), 32'(LS_DIRTY));
    go_idle();
  endtask

  task automatic test_eviction(input logic is_write, input index_t idx, input tag_t base);
    for (int i = 0; i < NUM_WAYS; i++) begin
      send_request(is_write, base + tag_t'(i), idx, 1'b0, 1'b1, 1'b1);
    end
    send_request(1'b0, base + tag_t'(NUM_WAYS), idx, 1'b0, 1'b1, 1'b1);
    check_value("evict way", 32'(last_isu.set_way_offset[3:1]), 32'd0);
    check_value("evict bit", 32'(last_isu.opcode[1]), 32'(is_write));
    go_idle();
  endtask

  task automatic test_back_pressure(input tag_t t);
    send_request(1'b0, t, 3'd5, 1'b0, 1'b1, 1'b0);
    send_request(1'b0, t, 3'd5, 1'b0, 1'b0, 1'b1);
    send_request(1'b0, t, 3'd5, 1'b0, 1'b1, 1'b1);
    check_value("miss after stall", 32'(last_isu.need_linefill), 32'd1);
    go_idle();
  endtask

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(32'he16c17fe));
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    isu_allow_in = 1'b0;
    biu_arready  = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      ref_vp[s] = 0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        ref_tag[s][w] = '0;
        ref_s0[s][w]  = LS_EMPTY;
        ref_s1[s][w]  = LS_EMPTY;
      end
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    go_idle();
    test_read_miss_then_hit(tag_t'($urandom()));
    test_other_half(ref_tag[1][0]);
    test_write_miss(tag_t'($urandom()));
    test_eviction(1'b1, 3'd3, tag_t'($urandom()));
    test_eviction(1'b0, 3'd4, tag_t'($urandom()));
    test_back_pressure(tag_t'($urandom()));
    $display("Test passed");
    $finish;
  end

endmodule

//--- bank_htu_top.f
common/htu_pkg.sv
set_array/htu_set_entry.sv
set_array/htu_set_array.sv
logic/htu_dispatch.sv
logic/bank_htu_top.sv
testbench/bank_htu_properties.sv
testbench/tb_bank_htu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_bank_htu
FILELIST  := bank_htu_top.f
MDIR      := obj_dir
BIN       := $(MDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
